/* rtl/multdiv_pkg.sv */
// Shared types and constants for the multiply/divide unit.
// Operand fields are fixed at xlen bits. Only xlen = 32 is verified.

package multdiv_pkg;

  localparam int unsigned xlen      = 32;
  localparam int unsigned half_w    = 16;
  localparam int unsigned div_steps = 32;
  localparam int unsigned div_cnt_w = $clog2(div_steps);

  // RV32M operation encoding, multiplies in the lower half
  typedef enum logic [2:0] {
    op_mul    = 3'd0,
    op_mulh   = 3'd1,
    op_mulhsu = 3'd2,
    op_mulhu  = 3'd3,
    op_div    = 3'd4,
    op_divu   = 3'd5,
    op_rem    = 3'd6,
    op_remu   = 3'd7
  } md_op_e;

  typedef struct packed {
    md_op_e          op;
    logic [xlen-1:0] op_a;
    logic [xlen-1:0] op_b;
  } md_req_t;

  typedef struct packed {
    logic [xlen-1:0] result;
  } md_resp_t;

  function automatic logic is_div(md_op_e op);
    return op inside {op_div, op_divu, op_rem, op_remu};
  endfunction

  // operand a is signed for mulh, mulhsu, div and rem
  function automatic logic sign_a_of(md_op_e op, logic [xlen-1:0] operand);
    logic signed_op;
    signed_op = op inside {op_mulh, op_mulhsu, op_div, op_rem};
    return signed_op & operand[xlen-1];
  endfunction

  // operand b is signed for mulh, div and rem
  function automatic logic sign_b_of(md_op_e op, logic [xlen-1:0] operand);
    logic signed_op;
    signed_op = op inside {op_mulh, op_div, op_rem};
    return signed_op & operand[xlen-1];
  endfunction

endpackage

/* rtl/multdiv_ctrl.sv */
// Request/response controller. Accepts one operation at a time and
// starts the matching unit one cycle after acceptance.
// req_ready_o returns one cycle after the response transfer.

`timescale 1ns/1ns

module multdiv_ctrl (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic                  req_valid_i,
  input  multdiv_pkg::md_req_t  req_i,
  output logic                  req_ready_o,
  output logic                  mul_start_o,
  output logic                  div_start_o,
  output multdiv_pkg::md_req_t  op_req_o,
  input  logic                  mul_done_i,
  input  multdiv_pkg::md_resp_t mul_resp_i,
  input  logic                  div_done_i,
  input  multdiv_pkg::md_resp_t div_resp_i,
  output logic                  resp_valid_o,
  output multdiv_pkg::md_resp_t resp_o,
  input  logic                  resp_ready_i
);

  logic                 busy_q;
  logic                 sel_div_q;
  logic                 mul_start_q;
  logic                 div_start_q;
  logic                 accept;
  logic                 req_is_div;
  multdiv_pkg::md_req_t req_q;

  assign req_ready_o = ~busy_q;
  assign accept      = req_valid_i & ~busy_q;
  assign req_is_div  = multdiv_pkg::is_div(req_i.op);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      busy_q      <= 1'b0;
      sel_div_q   <= 1'b0;
      mul_start_q <= 1'b0;
      div_start_q <= 1'b0;
    end else begin
      // one-cycle start pulse toward the selected unit
      mul_start_q <= accept & ~req_is_div;
      div_start_q <= accept & req_is_div;
      if (accept) begin
        busy_q    <= 1'b1;
        sel_div_q <= req_is_div;
      end else if (resp_valid_o && resp_ready_i) begin
        busy_q <= 1'b0;
      end
    end
  end

  // operands stay steady for the whole operation
  always_ff @(posedge clk_i) begin
    if (accept) begin
      req_q <= req_i;
    end
  end

  assign mul_start_o = mul_start_q;
  assign div_start_o = div_start_q;
  assign op_req_o    = req_q;

  // response comes from whichever unit is busy
  assign resp_valid_o = sel_div_q ? div_done_i : mul_done_i;
  assign resp_o       = sel_div_q ? div_resp_i : mul_resp_i;

endmodule

/* rtl/mult_unit.sv */
// Multiplier built on one signed 17x17 multiply-accumulate over operand halves.
// MUL finishes in the 3rd cycle after start and the MULH forms in the 4th.
// Operands must stay steady until the result is accepted.

`timescale 1ns/1ns

module mult_unit #(
  parameter int unsigned width_p = multdiv_pkg::xlen
) (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic                  start_i,
  input  multdiv_pkg::md_req_t  req_i,
  input  logic                  resp_ready_i,
  output logic                  done_o,
  output multdiv_pkg::md_resp_t resp_o
);

  localparam int unsigned hw    = multdiv_pkg::half_w;
  localparam int unsigned acc_w = width_p + 2;
  localparam int unsigned pad_w = acc_w - hw;

  typedef enum logic [2:0] {
    st_idle, st_albl, st_albh, st_ahbl, st_ahbh
  } state_e;

  state_e             state_q, state_d;
  logic [acc_w-1:0]   acc_q, acc_d;
  logic [acc_w-1:0]   accum;
  logic [acc_w-1:0]   mac;
  logic [hw-1:0]      op_a_half, op_b_half;
  logic               sign_a, sign_b;
  logic               is_mul;
  logic               signed_mult;
  logic [width_p-1:0] result;

  assign is_mul      = (req_i.op == multdiv_pkg::op_mul);
  assign signed_mult = (req_i.op != multdiv_pkg::op_mulhu);

  // 17x17 signed product plus 34-bit addend
  assign mac = $signed({sign_a, op_a_half}) * $signed({sign_b, op_b_half}) + $signed(accum);

  always_comb begin
    state_d   = state_q;
    acc_d     = acc_q;
    op_a_half = req_i.op_a[hw-1:0];
    op_b_half = req_i.op_b[hw-1:0];
    sign_a    = 1'b0;
    sign_b    = 1'b0;
    accum     = '0;
    result    = mac[width_p-1:0];
    done_o    = 1'b0;

    unique case (state_q)
      st_idle: begin
        if (start_i) begin
          state_d = st_albl;
        end
      end

      st_albl: begin
        // al*bl is always unsigned
        acc_d   = mac;
        state_d = st_albh;
      end

      st_albh: begin
        op_b_half = req_i.op_b[width_p-1 -: hw];
        sign_b    = multdiv_pkg::sign_b_of(req_i.op, req_i.op_b);
        accum     = {{pad_w{1'b0}}, acc_q[width_p-1:hw]};
        if (is_mul) begin
          acc_d = {2'b00, mac[hw-1:0], acc_q[hw-1:0]};
        end else begin
          acc_d = mac;
        end
        state_d = st_ahbl;
      end

      st_ahbl: begin
        op_a_half = req_i.op_a[width_p-1 -: hw];
        sign_a    = multdiv_pkg::sign_a_of(req_i.op, req_i.op_a);
        if (is_mul) begin
          // low word done, hold here until accepted
          accum  = {{pad_w{1'b0}}, acc_q[width_p-1:hw]};
          result = {mac[hw-1:0], acc_q[hw-1:0]};
          done_o = 1'b1;
          if (resp_ready_i) begin
            state_d = st_idle;
          end
        end else begin
          accum   = acc_q;
          acc_d   = mac;
          state_d = st_ahbh;
        end
      end

      st_ahbh: begin
        op_a_half = req_i.op_a[width_p-1 -: hw];
        op_b_half = req_i.op_b[width_p-1 -: hw];
        sign_a    = multdiv_pkg::sign_a_of(req_i.op, req_i.op_a);
        sign_b    = multdiv_pkg::sign_b_of(req_i.op, req_i.op_b);
        // shift partial sum down by one half, sign extended unless mulhu
        accum     = {{hw{signed_mult & acc_q[acc_w-1]}}, acc_q[acc_w-1:hw]};
        done_o    = 1'b1;
        if (resp_ready_i) begin
          state_d = st_idle;
        end
      end

      default: begin
        state_d = st_idle;
      end
    endcase
  end

  assign resp_o.result = result;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= st_idle;
    end else begin
      state_q <= state_d;
    end
  end

  always_ff @(posedge clk_i) begin
    acc_q <= acc_d;
  end

endmodule

/* rtl/div_unit.sv */
// Restoring long divider for DIV, DIVU, REM and REMU.
// Takes 36 cycles from start to done and 2 cycles on division by zero.
// Operands must stay steady until the result is accepted.

`timescale 1ns/1ns

module div_unit #(
  parameter int unsigned width_p = multdiv_pkg::xlen
) (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic                  start_i,
  input  multdiv_pkg::md_req_t  req_i,
  input  logic                  resp_ready_i,
  output logic                  done_o,
  output multdiv_pkg::md_resp_t resp_o
);

  localparam int unsigned cnt_w = multdiv_pkg::div_cnt_w;

  typedef enum logic [2:0] {
    st_idle, st_abs_a, st_abs_b, st_comp, st_last, st_change_sign, st_finish
  } state_e;

  state_e             state_q, state_d;
  logic [width_p-1:0] num_q, num_d;
  logic [width_p-1:0] den_q, den_d;
  logic [width_p-1:0] quot_q, quot_d;
  logic [width_p:0]   rem_q, rem_d;
  logic [cnt_w-1:0]   cnt_q, cnt_d;
  logic               dbz_q, dbz_d;
  logic [width_p:0]   sub_a, sub_b, sub_res;
  logic               ge;
  logic [width_p-1:0] next_rem;
  logic [width_p-1:0] next_quot;
  logic               sign_a, sign_b;
  logic               quot_op;
  logic               div_change_sign;
  logic               rem_change_sign;

  assign sign_a  = multdiv_pkg::sign_a_of(req_i.op, req_i.op_a);
  assign sign_b  = multdiv_pkg::sign_b_of(req_i.op, req_i.op_b);
  assign quot_op = (req_i.op == multdiv_pkg::op_div) || (req_i.op == multdiv_pkg::op_divu);

  // quotient sign flips on mixed signs except after a zero divisor
  assign div_change_sign = (sign_a ^ sign_b) & ~dbz_q;
  assign rem_change_sign = sign_a;

  // shared subtractor for negation and the trial subtraction
  assign sub_res = sub_a - sub_b;

  // partial remainder is below twice the divisor so bit width_p is the borrow
  assign ge        = ~sub_res[width_p];
  assign next_rem  = ge ? sub_res[width_p-1:0] : rem_q[width_p-1:0];
  assign next_quot = quot_q | ({{(width_p-1){1'b0}}, ge} << cnt_q);

  always_comb begin
    state_d = state_q;
    num_d   = num_q;
    den_d   = den_q;
    quot_d  = quot_q;
    rem_d   = rem_q;
    cnt_d   = cnt_q;
    dbz_d   = dbz_q;
    sub_a   = rem_q;
    sub_b   = {1'b0, den_q};
    done_o  = 1'b0;

    unique case (state_q)
      st_idle: begin
        if (start_i) begin
          dbz_d   = (req_i.op_b == '0);
          state_d = st_abs_a;
        end
      end

      st_abs_a: begin
        sub_a = '0;
        sub_b = {1'b0, req_i.op_a};
        if (dbz_q) begin
          // all ones for the quotient, dividend for the remainder
          rem_d   = {1'b0, (quot_op ? {width_p{1'b1}} : req_i.op_a)};
          state_d = st_finish;
        end else begin
          num_d   = sign_a ? sub_res[width_p-1:0] : req_i.op_a;
          state_d = st_abs_b;
        end
      end

      st_abs_b: begin
        sub_a   = '0;
        sub_b   = {1'b0, req_i.op_b};
        den_d   = sign_b ? sub_res[width_p-1:0] : req_i.op_b;
        rem_d   = {{width_p{1'b0}}, num_q[width_p-1]};
        quot_d  = '0;
        cnt_d   = cnt_w'(multdiv_pkg::div_steps - 1);
        state_d = st_comp;
      end

      st_comp: begin
        cnt_d   = cnt_q - 1'b1;
        quot_d  = next_quot;
        // shift in the next numerator bit
        rem_d   = {next_rem, num_q[cnt_d]};
        state_d = (cnt_q == cnt_w'(1)) ? st_last : st_comp;
      end

      st_last: begin
        // keep only the word that is returned
        rem_d   = {1'b0, (quot_op ? next_quot : next_rem)};
        state_d = st_change_sign;
      end

      st_change_sign: begin
        sub_a = '0;
        sub_b = rem_q;
        if (quot_op ? div_change_sign : rem_change_sign) begin
          rem_d = {1'b0, sub_res[width_p-1:0]};
        end
        state_d = st_finish;
      end

      st_finish: begin
        done_o = 1'b1;
        if (resp_ready_i) begin
          state_d = st_idle;
        end
      end

      default: begin
        state_d = st_idle;
      end
    endcase
  end

  assign resp_o.result = rem_q[width_p-1:0];

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= st_idle;
      cnt_q   <= '0;
      dbz_q   <= 1'b0;
    end else begin
      state_q <= state_d;
      cnt_q   <= cnt_d;
      dbz_q   <= dbz_d;
    end
  end

  always_ff @(posedge clk_i) begin
    num_q  <= num_d;
    den_q  <= den_d;
    quot_q <= quot_d;
    rem_q  <= rem_d;
  end

endmodule

/* rtl/multdiv_top.sv */
// Multiply/divide unit top level with valid/ready request and response ports.
// One operation in flight at a time. Verified only with width_p = 32.

`timescale 1ns/1ns

module multdiv_top #(
  parameter int unsigned width_p = multdiv_pkg::xlen
) (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic                  req_valid_i,
  input  multdiv_pkg::md_req_t  req_i,
  output logic                  req_ready_o,
  output logic                  resp_valid_o,
  output multdiv_pkg::md_resp_t resp_o,
  input  logic                  resp_ready_i
);

  logic                  mul_start, div_start;
  logic                  mul_done, div_done;
  multdiv_pkg::md_req_t  op_req;
  multdiv_pkg::md_resp_t mul_resp, div_resp;

  multdiv_ctrl multdiv_ctrl_inst (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .req_valid_i  (req_valid_i),
    .req_i        (req_i),
    .req_ready_o  (req_ready_o),
    .mul_start_o  (mul_start),
    .div_start_o  (div_start),
    .op_req_o     (op_req),
    .mul_done_i   (mul_done),
    .mul_resp_i   (mul_resp),
    .div_done_i   (div_done),
    .div_resp_i   (div_resp),
    .resp_valid_o (resp_valid_o),
    .resp_o       (resp_o),
    .resp_ready_i (resp_ready_i)
  );

  mult_unit #(
    .width_p (width_p)
  ) mult_unit_inst (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .start_i      (mul_start),
    .req_i        (op_req),
    .resp_ready_i (resp_ready_i),
    .done_o       (mul_done),
    .resp_o       (mul_resp)
  );

  div_unit #(
    .width_p (width_p)
  ) div_unit_inst (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .start_i      (div_start),
    .req_i        (op_req),
    .resp_ready_i (resp_ready_i),
    .done_o       (div_done),
    .resp_o       (div_resp)
  );

endmodule

/* testbench/multdiv_assertions.sv */
// Reference model and protocol checks for multdiv_top, attached with bind.
// Expected results follow the RV32M rules and assume width_p = 32.

`timescale 1ns/1ns

module multdiv_assertions (
  input logic                  clk_i,
  input logic                  rst_ni,
  input logic                  req_valid_i,
  input multdiv_pkg::md_req_t  req_i,
  input logic                  req_ready_o,
  input logic                  resp_valid_o,
  input multdiv_pkg::md_resp_t resp_o,
  input logic                  resp_ready_i
);

  logic [31:0] exp_q;
  logic [31:0] got_q = '0;
  logic        in_flight_q;
  // 1 wrong result, 2 stalled response not held, 3 ready out of step with busy
  logic [1:0]  fail_kind = 2'd0;
  int unsigned fail_count = 0;

  function automatic logic [31:0] model_result(multdiv_pkg::md_op_e op, logic [31:0] a,
                                               logic [31:0] b);
    logic [63:0]        a_s;
    logic [63:0]        a_u;
    logic [63:0]        b_s;
    logic [63:0]        b_u;
    logic [63:0]        prod;
    logic signed [31:0] a_sw;
    logic signed [31:0] b_sw;
    logic               dbz;
    logic               ovf;
    logic [31:0]        res;
    a_s  = {{32{a[31]}}, a};
    a_u  = {32'b0, a};
    b_s  = {{32{b[31]}}, b};
    b_u  = {32'b0, b};
    a_sw = a;
    b_sw = b;
    dbz  = (b == 32'h0);
    ovf  = (a == 32'h8000_0000) && (b == 32'hffff_ffff);
    prod = '0;
    res  = '0;
    // every branch signed, one unsigned branch would make the divide unsigned
    case (op)
      multdiv_pkg::op_mul:    res = a * b;
      multdiv_pkg::op_mulh:   prod = a_s * b_s;
      multdiv_pkg::op_mulhsu: prod = a_s * b_u;
      multdiv_pkg::op_mulhu:  prod = a_u * b_u;
      multdiv_pkg::op_div:    res = dbz ? 32'shffff_ffff : (ovf ? a_sw : a_sw / b_sw);
      multdiv_pkg::op_divu:   res = dbz ? 32'hffff_ffff : a / b;
      multdiv_pkg::op_rem:    res = dbz ? a_sw : (ovf ? 32'sd0 : a_sw % b_sw);
      default:                res = dbz ? a : a % b;
    endcase
    // high product word for the three mulh forms
    if (op inside {multdiv_pkg::op_mulh, multdiv_pkg::op_mulhsu, multdiv_pkg::op_mulhu}) begin
      res = prod[63:32];
    end
    return res;
  endfunction

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      in_flight_q <= 1'b0;
    end else if (req_valid_i && req_ready_o) begin
      in_flight_q <= 1'b1;
    end else if (resp_valid_o && resp_ready_i) begin
      in_flight_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (req_valid_i && req_ready_o) begin
      exp_q <= model_result(req_i.op, req_i.op_a, req_i.op_b);
    end
  end

  a_result: assert property (@(posedge clk_i) disable iff (!rst_ni)
    resp_valid_o |-> (resp_o.result == exp_q))
    else begin
      got_q = $sampled(resp_o.result);
      fail_kind = 2'd1;
      fail_count++;
      $error("result differs from the reference model");
    end

  // stalled response keeps its value and blocks new requests
  a_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (resp_valid_o && !resp_ready_i) |=>
      (resp_valid_o && $stable(resp_o.result) && !req_ready_o))
    else begin
      fail_kind = 2'd2;
      fail_count++;
      $error("stalled response was not held");
    end

  a_single: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (req_ready_o == !in_flight_q) && (!resp_valid_o || in_flight_q))
    else begin
      fail_kind = 2'd3;
      fail_count++;
      $error("request ready does not follow the in-flight state");
    end

endmodule

bind multdiv_top multdiv_assertions multdiv_assertions_inst (
  .clk_i        (clk_i),
  .rst_ni       (rst_ni),
  .req_valid_i  (req_valid_i),
  .req_i        (req_i),
  .req_ready_o  (req_ready_o),
  .resp_valid_o (resp_valid_o),
  .resp_o       (resp_o),
  .resp_ready_i (resp_ready_i)
);

/* testbench/tb_multdiv.sv */
// Testbench for multdiv_top. Result and handshake checks sit in the bound
// assertion module; this file drives corner and seeded random operations.

`timescale 1ns/1ns

module tb_multdiv;

  localparam int unsigned clk_period = 40;
  localparam int unsigned n_corner   = 4 * 4 * 8;
  localparam int unsigned n_random   = 25;
  localparam int unsigned n_ops      = n_corner + n_random * 8;
  localparam int unsigned seed       = 32'he648_8468;
  // a divide takes 36 cycles plus up to 5 stalled cycles and the handshakes
  localparam time         run_limit  = n_ops * 50 * clk_period + 100 * clk_period;

  logic                  clk_i;
  logic                  rst_ni;
  logic                  req_valid_i;
  multdiv_pkg::md_req_t  req_i;
  logic                  req_ready_o;
  logic                  resp_valid_o;
  multdiv_pkg::md_resp_t resp_o;
  logic                  resp_ready_i;
  string                 test_name;

  multdiv_top #(
    .width_p (multdiv_pkg::xlen)
  ) multdiv_top_inst (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .req_valid_i  (req_valid_i),
    .req_i        (req_i),
    .req_ready_o  (req_ready_o),
    .resp_valid_o (resp_valid_o),
    .resp_o       (resp_o),
    .resp_ready_i (resp_ready_i)
  );

  initial begin
    clk_i = 1'b0;
    forever #(clk_period / 2) clk_i = ~clk_i;
  end

  function automatic logic [31:0] corner_value(int unsigned idx);
    case (idx)
      0:       return 32'h0000_0000;
      1:       return 32'h0000_0001;
      2:       return 32'hffff_ffff;
      default: return 32'h8000_0000;
    endcase
  endfunction

  // spread magnitudes so small divisors and both signs show up
  function automatic logic [31:0] random_operand();
    logic [31:0] v;
    v = $urandom() >> $urandom_range(0, 31);
    if ($urandom_range(0, 1) == 1) begin
      v = -v;
    end
    return v;
  endfunction

  task automatic send_request(input multdiv_pkg::md_op_e op, input logic [31:0] a,
                              input logic [31:0] b);
    @(negedge clk_i);
    req_valid_i = 1'b1;
    req_i.op    = op;
    req_i.op_a  = a;
    req_i.op_b  = b;
    // ready seen at a falling edge holds through the next rising edge
    while (!req_ready_o) @(negedge clk_i);
    @(negedge clk_i);
    req_valid_i = 1'b0;
  endtask

  task automatic take_response(input int unsigned stall);
    resp_ready_i = (stall == 0);
    while (!resp_valid_o) @(negedge clk_i);
    repeat (stall) @(negedge clk_i);
    resp_ready_i = 1'b1;
    @(negedge clk_i);
  endtask

  task automatic run_op(input string name, input multdiv_pkg::md_op_e op,
                        input logic [31:0] a, input logic [31:0] b);
    int unsigned stall;
    stall     = ($urandom_range(0, 1) == 1) ? $urandom_range(1, 5) : 0;
    test_name = name;
    send_request(op, a, b);
    take_response(stall);
  endtask

  initial begin : stimulus
    multdiv_pkg::md_op_e op;
    void'($urandom(seed));
    rst_ni       = 1'b0;
    req_valid_i  = 1'b0;
    req_i        = '0;
    resp_ready_i = 1'b1;
    test_name    = "reset";
    repeat (5) @(posedge clk_i);
    @(negedge clk_i);
    rst_ni = 1'b1;
    for (int o = 0; o < 8; o++) begin
      op = multdiv_pkg::md_op_e'(o);
      for (int i = 0; i < 4; i++) begin
        for (int j = 0; j < 4; j++) begin
          run_op($sformatf("corner %s", op.name()), op, corner_value(i), corner_value(j));
        end
      end
    end
    for (int o = 0; o < 8; o++) begin
      op = multdiv_pkg::md_op_e'(o);
      for (int k = 0; k < n_random; k++) begin
        run_op($sformatf("random %s", op.name()), op, random_operand(), random_operand());
      end
    end
    repeat (4) @(negedge clk_i);
    if (multdiv_top_inst.multdiv_assertions_inst.fail_count == 0) begin
      $display("RESULT: PASS");
      $finish;
    end else begin
      $display("RESULT: FAIL");
      $fatal(1, "assertion failures were recorded");
    end
  end

  initial begin : error_monitor
    wait (multdiv_top_inst.multdiv_assertions_inst.fail_count != 0);
    if (multdiv_top_inst.multdiv_assertions_inst.fail_kind == 2'd1) begin
      $display("MISMATCH test=%s expected=%08h actual=%08h", test_name,
               multdiv_top_inst.multdiv_assertions_inst.exp_q,
               multdiv_top_inst.multdiv_assertions_inst.got_q);
    end else if (multdiv_top_inst.multdiv_assertions_inst.fail_kind == 2'd2) begin
      $display("ERROR test=%s: stalled response changed or request ready rose", test_name);
    end else begin
      $display("ERROR test=%s: request ready did not follow the in-flight state", test_name);
    end
    $display("RESULT: FAIL");
    $fatal(1, "stopped at the first failed check");
  end

  initial begin : watchdog
    #(run_limit);
    $display("ERROR: run did not finish within %0t ns, the DUT stopped responding", run_limit);
    $display("RESULT: FAIL");
    $fatal(1, "watchdog timeout");
  end

endmodule

/* filelist.f */
rtl/multdiv_pkg.sv
rtl/multdiv_ctrl.sv
rtl/mult_unit.sv
rtl/div_unit.sv
rtl/multdiv_top.sv
testbench/multdiv_assertions.sv
testbench/tb_multdiv.sv

/* Bender.yml */
package:
  name: multdiv

sources:
  # RTL
  - files:
      - rtl/multdiv_pkg.sv
      - rtl/multdiv_ctrl.sv
      - rtl/mult_unit.sv
      - rtl/div_unit.sv
      - rtl/multdiv_top.sv
  # testbench
  - target: test
    files:
      - testbench/multdiv_assertions.sv
      - testbench/tb_multdiv.sv
